//--- processor_input.txt
// columns in hex: op arg1 arg2, a line with op 0 ends the list
// op 1 redirect target count, 2 load addr word, 3 cached cycles, 4 busy load, 5 load hit
00000002 00001000 13578bdf
00000005 00001004 13578bdb
00000002 0000204c 1357bb93
00000005 00002048 1357bb97
00000001 00000000 00000028
00000001 000002a0 00000004
00000001 00000000 00000001
00000003 00000014 00000000
00000004 00003010 1357abcf
00000002 00000400 13579fdf
00000001 00000500 00000008
00000002 00001000 13578bdf
00000005 00001004 13578bdb
00000000 00000000 00000000

//--- compile.f
sys_defs_pkg.sv
pipe_defs_pkg.sv
fetch_stage.sv
icache.sv
load_unit.sv
mem_arbiter.sv
processor.sv
tb_clock_gen.sv
processor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, and checks the log for a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module processor_tb \
    -o sim_processor > build.log 2>&1 \
    && ./obj_dir/sim_processor > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- processor_tb.sv
// testbench for the processor front end and memory side
// reads operations from processor_input.txt, models a tagged memory with
// random rejection and latency, and checks fetch packets and load results
`timescale 1ns/1ps

module processor_tb;
    import sys_defs_pkg::*;
    import pipe_defs_pkg::*;

    localparam logic [31:0] data_key = 32'h13579bdf;   // data rule mask
    localparam int          max_ops  = 64;

    logic clock;
    logic rst;
    redirect_t                  redirect;
    load_req_t                  load_req;
    logic [tag_bits-1:0]        mem2proc_response = '0;
    logic [block_bits-1:0]      mem2proc_data     = '0;
    logic [tag_bits-1:0]        mem2proc_tag      = '0;
    mem_command_t               proc2mem_command;
    logic [xlen-1:0]            proc2mem_addr;
    logic [block_bits-1:0]      proc2mem_data;
    mem_size_t                  proc2mem_size;
    fetch_packet_t              fetch_packet;
    logic                       load_busy;
    load_result_t               load_result;

    logic [31:0] ops [3*max_ops];   // op, arg1, arg2 per line
    int          num_ops;
    int          err_fetch;
    int          err_load;
    int          err_cmd;
    int          err_bus;           // size and data pins
    int          err_other;

    tb_clock_gen clk0 (.clock(clock), .rst(rst));

    processor u_processor (.*);

    //////////////////////////////
    // data rule and random source
    //////////////////////////////
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return a ^ data_key;            // word at any aligned address
    endfunction

    logic [31:0] lfsr = 32'h4b725410;

    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r     = (r << 1) | int'(lfsr[0]);
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);   // galois step
        end
        return r;
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_fetch(input string name, input fetch_packet_t exp,
                               input fetch_packet_t act);
        if (exp !== act) begin
            err_fetch++;
            $display("Error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_load(input string name, input load_result_t exp,
                              input load_result_t act);
        if (exp !== act) begin
            err_load++;
            $display("Error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_command(input string name, input mem_command_t exp,
                                 input mem_command_t act);
        if (exp !== act) begin
            err_cmd++;
            $display("Error %s: expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_size(input string name, input mem_size_t exp,
                              input mem_size_t act);
        if (exp !== act) begin
            err_bus++;
            $display("Error %s: expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_bus_data(input string name, input logic [block_bits-1:0] exp,
                                  input logic [block_bits-1:0] act);
        if (exp !== act) begin
            err_bus++;
            $display("Error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    //////////////////////////////
    // memory model
    //////////////////////////////
    mem_command_t    s_cmd;          // bus seen mid-cycle
    logic [xlen-1:0] s_addr;
    logic [3:0]      s_resp;
    logic [3:0]      next_tag = 4'd1;
    int              cyc;
    int              q_due  [$];
    logic [3:0]      q_tag  [$];
    logic [31:0]     q_addr [$];
    int              pick;

    always @(negedge clock) begin
        s_cmd  <= proc2mem_command;
        s_addr <= proc2mem_addr;
        s_resp <= mem2proc_response;
        if (!rst) begin
            check_bus_data("store data", '0, proc2mem_data);     // no store ever issued
            if (proc2mem_command == cmd_load) begin
                check_size("request size", size_double, proc2mem_size);
            end
        end
    end

    always @(posedge clock) begin
        if (rst) begin
            mem2proc_response <= '0;
            mem2proc_tag      <= '0;
            cyc = 0;
        end else begin
            cyc++;
            if (s_cmd == cmd_load && s_resp != 0) begin    // tag consumed last cycle
                q_due.push_back(cyc + 2 + rand_bits(2));   // 3..6 cycles after accept
                q_tag.push_back(s_resp);
                q_addr.push_back(s_addr);
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            mem2proc_response <= (rand_bits(2) != 0) ? next_tag : 4'd0;   // 3/4 accept
            pick = -1;
            foreach (q_due[i]) if (pick < 0 && q_due[i] <= cyc) pick = i;
            if (pick >= 0) begin
                mem2proc_tag  <= q_tag[pick];
                mem2proc_data <= {word_at(q_addr[pick] + 4), word_at(q_addr[pick])};
                q_due.delete(pick);
                q_tag.delete(pick);
                q_addr.delete(pick);
            end else begin
                mem2proc_tag <= '0;
            end
        end
    end

    //////////////////////////////
    // fetch monitor
    //////////////////////////////
    logic [31:0]   exp_pc = '0;
    int            pkt_count;
    fetch_packet_t exp_pkt;

    always @(negedge clock) begin
        if (!rst) begin
            if (fetch_packet.valid) begin
                exp_pkt = '{valid: 1'b1, pc: exp_pc, inst: word_at(exp_pc)};
                check_fetch("fetch", exp_pkt, fetch_packet);
                exp_pc = exp_pc + 4;
                pkt_count++;
            end
            if (redirect.valid) begin       // old path ends this cycle
                exp_pc    = redirect.target;
                pkt_count = 0;
            end
        end
    end

    //////////////////////////////
    // operations
    //////////////////////////////
    task automatic issue_load(input logic [31:0] addr);
        @(posedge clock);
        load_req <= '{valid: 1'b1, addr: addr};
        @(posedge clock);
        load_req.valid <= 1'b0;
    endtask

    task automatic wait_load(input logic [31:0] addr, input logic [31:0] word);
        do @(negedge clock); while (!load_result.valid);
        check_load("load", '{valid: 1'b1, addr: addr, data: word}, load_result);
    endtask

    task automatic run_redirect(input logic [31:0] target, input int count);
        @(posedge clock);
        redirect <= '{valid: 1'b1, target: target};
        @(posedge clock);
        redirect.valid <= 1'b0;
        wait (pkt_count >= count);
    endtask

    task automatic check_cached(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_command("cache idle", cmd_none, proc2mem_command);
            if (!fetch_packet.valid) begin
                err_other++;
                $display("no fetch packet in a cycle that should hit the cache");
            end
        end
    endtask

    task automatic load_hit(input logic [31:0] addr, input logic [31:0] word);
        issue_load(addr);
        @(negedge clock);           // exactly one cycle after the request
        check_load("load hit", '{valid: 1'b1, addr: addr, data: word}, load_result);
        if (proc2mem_command == cmd_load && proc2mem_addr == {addr[31:3], 3'b000}) begin
            err_other++;
            $display("buffered load went out to memory");
        end
    endtask

    task automatic load_while_busy(input logic [31:0] addr, input logic [31:0] word);
        issue_load(addr);
        do @(negedge clock); while (!load_busy);
        @(posedge clock);
        load_req <= '{valid: 1'b1, addr: addr ^ 32'h800};   // must be dropped
        @(posedge clock);
        load_req.valid <= 1'b0;
        wait_load(addr, word);
        repeat (6) begin
            @(negedge clock);
            if (load_result.valid || load_busy) begin
                err_other++;
                $display("load requested while busy was not dropped");
            end
        end
    endtask

    initial begin : watchdog
        @(negedge rst);
        repeat (200 * (num_ops + 1)) @(posedge clock);
        $display("watchdog expired, operations did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int op;
        redirect = '0;
        load_req = '0;
        $readmemh("processor_input.txt", ops);
        num_ops = 0;
        while (num_ops < max_ops && ops[3*num_ops] !== 32'h0) num_ops++;
        @(negedge clock);
        check_command("reset", cmd_none, proc2mem_command);
        if (fetch_packet.valid || load_result.valid || load_busy) begin
            err_other++;
            $display("outputs not idle during reset");
        end
        wait (!rst);
        for (op = 0; op < num_ops; op++) begin
            case (ops[3*op])
                32'h1: run_redirect(ops[3*op+1], ops[3*op+2]);
                32'h2: begin
                    issue_load(ops[3*op+1]);
                    wait_load(ops[3*op+1], ops[3*op+2]);
                end
                32'h3: check_cached(ops[3*op+1]);
                32'h4: load_while_busy(ops[3*op+1], ops[3*op+2]);
                32'h5: load_hit(ops[3*op+1], ops[3*op+2]);
                default: begin
                    err_other++;
                    $display("unknown operation code in input line %0d", op);
                end
            endcase
        end
        $display("errors: fetch %0d load %0d command %0d bus %0d other %0d",
                 err_fetch, err_load, err_cmd, err_bus, err_other);
        if (err_fetch + err_load + err_cmd + err_bus + err_other == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
// clock and reset source for the processor testbench
// 40 ns clock, rst held high for the first 16 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst
);
    localparam time half_period = 20ns;

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clock);
        rst <= 1'b0;    // released on an edge, like the other inputs
    end

endmodule

//--- processor.sv
// top level of the fetch and memory side
// connects fetch, icache, load unit and the bus arbiter to the memory pins
`timescale 1ns/1ps

module processor (
    input  logic                                clock,
    input  logic                                rst,
    input  pipe_defs_pkg::redirect_t            redirect,
    input  pipe_defs_pkg::load_req_t            load_req,
    input  logic [sys_defs_pkg::tag_bits-1:0]   mem2proc_response,
    input  logic [sys_defs_pkg::block_bits-1:0] mem2proc_data,
    input  logic [sys_defs_pkg::tag_bits-1:0]   mem2proc_tag,
    output sys_defs_pkg::mem_command_t          proc2mem_command,
    output logic [sys_defs_pkg::xlen-1:0]       proc2mem_addr,
    output logic [sys_defs_pkg::block_bits-1:0] proc2mem_data,
    output sys_defs_pkg::mem_size_t             proc2mem_size,
    output pipe_defs_pkg::fetch_packet_t        fetch_packet,
    output logic                                load_busy,
    output pipe_defs_pkg::load_result_t         load_result
);
    import sys_defs_pkg::*;

    logic [xlen-1:0]       fetch_addr;     // fetch -> icache
    logic                  hit_valid;      // icache -> fetch
    logic [block_bits-1:0] hit_data;
    mem_req_t              ic_req;         // clients -> arbiter
    mem_req_t              ld_req;
    mem_port_rsp_t         ic_rsp;         // arbiter -> clients
    mem_port_rsp_t         ld_rsp;

    //////////////////////////////
    // fetch path
    //////////////////////////////
    fetch_stage fetch_stage0 (
        .clock        (clock),
        .rst          (rst),
        .redirect     (redirect),
        .hit_valid    (hit_valid),
        .hit_data     (hit_data),
        .fetch_addr   (fetch_addr),
        .fetch_packet (fetch_packet)
    );

    icache icache0 (
        .clock      (clock),
        .rst        (rst),
        .fetch_addr (fetch_addr),
        .hit_valid  (hit_valid),
        .hit_data   (hit_data),
        .mem_req    (ic_req),
        .mem_rsp    (ic_rsp)
    );

    //////////////////////////////
    // load path and bus
    //////////////////////////////
    load_unit load_unit0 (
        .clock       (clock),
        .rst         (rst),
        .load_req    (load_req),
        .load_busy   (load_busy),
        .load_result (load_result),
        .mem_req     (ld_req),
        .mem_rsp     (ld_rsp)
    );

    mem_arbiter mem_arbiter0 (
        .clock             (clock),
        .rst               (rst),
        .ic_req            (ic_req),
        .ld_req            (ld_req),
        .ic_rsp            (ic_rsp),
        .ld_rsp            (ld_rsp),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .proc2mem_data     (proc2mem_data),
        .proc2mem_size     (proc2mem_size)
    );

endmodule

//--- mem_arbiter.sv
// round-robin arbiter between the icache and the load unit for the memory bus
// accepted pulses go to the granted client, fills go to the owner of the tag
// owner table is indexed by memory tag, entry freed when its data returns
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                                clock,
    input  logic                                rst,
    input  sys_defs_pkg::mem_req_t              ic_req,
    input  sys_defs_pkg::mem_req_t              ld_req,
    output sys_defs_pkg::mem_port_rsp_t         ic_rsp,
    output sys_defs_pkg::mem_port_rsp_t         ld_rsp,
    input  logic [sys_defs_pkg::tag_bits-1:0]   mem2proc_response,   // 0 = rejected
    input  logic [sys_defs_pkg::block_bits-1:0] mem2proc_data,
    input  logic [sys_defs_pkg::tag_bits-1:0]   mem2proc_tag,        // nonzero = data valid
    output sys_defs_pkg::mem_command_t          proc2mem_command,
    output logic [sys_defs_pkg::xlen-1:0]       proc2mem_addr,
    output logic [sys_defs_pkg::block_bits-1:0] proc2mem_data,
    output sys_defs_pkg::mem_size_t             proc2mem_size
);
    import sys_defs_pkg::*;

    logic ic_want;
    logic ld_want;
    logic grant_ic;
    logic grant_ld;
    logic last_ld;          // load unit was served last
    logic accepted;
    logic fill_known;       // returned tag is in the table

    logic [num_tags-1:0] tag_busy;
    logic [num_tags-1:0] tag_is_ld;    // owner, 1 = load unit
    mem_req_t            sel_req;

    //////////////////////////////
    // grant
    //////////////////////////////
    assign ic_want  = (ic_req.command != cmd_none);
    assign ld_want  = (ld_req.command != cmd_none);
    assign grant_ld = ld_want && (!ic_want || !last_ld);     // tie goes to the other one
    assign grant_ic = ic_want && !grant_ld;
    assign sel_req  = grant_ld ? ld_req : ic_req;            // none when nobody asks

    assign proc2mem_command = sel_req.command;
    assign proc2mem_addr    = sel_req.addr;
    assign proc2mem_size    = sel_req.size;
    assign proc2mem_data    = '0;                            // loads only

    assign accepted   = (mem2proc_response != '0);
    assign fill_known = (mem2proc_tag != '0) && tag_busy[mem2proc_tag];

    //////////////////////////////
    // response routing
    //////////////////////////////
    always_comb begin
        ic_rsp.accepted   = grant_ic && accepted;
        ic_rsp.fill_valid = fill_known && !tag_is_ld[mem2proc_tag];
        ic_rsp.fill_data  = mem2proc_data;
        ld_rsp.accepted   = grant_ld && accepted;
        ld_rsp.fill_valid = fill_known && tag_is_ld[mem2proc_tag];
        ld_rsp.fill_data  = mem2proc_data;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            tag_busy <= '0;          // table clear
            last_ld  <= 1'b1;        // icache wins the first tie
        end else begin
            if (mem2proc_tag != '0) tag_busy[mem2proc_tag] <= 1'b0;
            // new tag recorded after the free, a reused tag stays owned
            if (accepted && (grant_ic || grant_ld)) begin
                tag_busy[mem2proc_response]  <= 1'b1;
                tag_is_ld[mem2proc_response] <= grant_ld;
                last_ld                      <= grant_ld;   // rejects leave the pointer
            end
        end
    end

endmodule

//--- load_unit.sv
// blocking load unit with a single 64-bit block buffer
// a request to the buffered block answers next cycle, otherwise the unit
// goes busy, loads the block over the bus and answers on fill
`timescale 1ns/1ps

module load_unit (
    input  logic                         clock,
    input  logic                         rst,
    input  pipe_defs_pkg::load_req_t     load_req,
    output logic                         load_busy,      // new requests ignored
    output pipe_defs_pkg::load_result_t  load_result,
    output sys_defs_pkg::mem_req_t       mem_req,
    input  sys_defs_pkg::mem_port_rsp_t  mem_rsp
);
    import sys_defs_pkg::*;
    import pipe_defs_pkg::*;

    typedef enum logic [1:0] {
        ld_idle,
        ld_wait_accept,
        ld_wait_fill
    } ld_state_t;

    ld_state_t                       state;
    logic                            buf_valid;
    logic [xlen-1:block_offset_bits] buf_block;     // block address of buf_data
    logic [block_bits-1:0]           buf_data;
    logic [xlen-1:0]                 pend_addr;     // full byte addr of the miss
    logic                            buf_hit;

    // word of a block picked by addr bit 2
    function automatic logic [word_bits-1:0] word_of(input logic [block_bits-1:0] blk,
                                                     input logic upper);
        return upper ? blk[block_bits-1:word_bits] : blk[word_bits-1:0];
    endfunction

    assign load_busy = (state != ld_idle);
    assign buf_hit   = buf_valid && (buf_block == load_req.addr[xlen-1:block_offset_bits]);

    always_comb begin
        mem_req.command = (state == ld_wait_accept) ? cmd_load : cmd_none;
        mem_req.addr    = {pend_addr[xlen-1:block_offset_bits], {block_offset_bits{1'b0}}};
        mem_req.size    = size_double;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state             <= ld_idle;
            buf_valid         <= 1'b0;
            load_result.valid <= 1'b0;
        end else begin
            load_result.valid <= 1'b0;      // one-cycle pulse
            case (state)
                ld_idle: begin
                    if (load_req.valid && buf_hit) begin
                        load_result.valid <= 1'b1;
                        load_result.addr  <= load_req.addr;
                        load_result.data  <= word_of(buf_data, load_req.addr[2]);
                    end else if (load_req.valid) begin
                        pend_addr <= load_req.addr;
                        state     <= ld_wait_accept;
                    end
                end
                ld_wait_accept: begin
                    if (mem_rsp.accepted) state <= ld_wait_fill;
                end
                ld_wait_fill: begin
                    if (mem_rsp.fill_valid) begin
                        buf_valid         <= 1'b1;
                        buf_block         <= pend_addr[xlen-1:block_offset_bits];
                        buf_data          <= mem_rsp.fill_data;
                        load_result.valid <= 1'b1;
                        load_result.addr  <= pend_addr;
                        load_result.data  <= word_of(mem_rsp.fill_data, pend_addr[2]);
                        state             <= ld_idle;
                    end
                end
                default: state <= ld_idle;
            endcase
        end
    end

endmodule

//--- icache.sv
// direct-mapped instruction cache, 32 lines of one 64-bit block each
// hit answers are registered one cycle after fetch_addr
// a miss issues one block load and answers the pending address on fill
`timescale 1ns/1ps

module icache (
    input  logic                                clock,
    input  logic                                rst,
    input  logic [sys_defs_pkg::xlen-1:0]       fetch_addr,
    output logic                                hit_valid,
    output logic [sys_defs_pkg::block_bits-1:0] hit_data,
    output sys_defs_pkg::mem_req_t              mem_req,
    input  sys_defs_pkg::mem_port_rsp_t         mem_rsp
);
    import sys_defs_pkg::*;

    typedef enum logic [1:0] {
        ic_idle,
        ic_wait_accept,     // request on the bus, retried until accepted
        ic_wait_fill        // tag handed out, waiting for data
    } ic_state_t;

    logic [icache_tag_bits-1:0] tag_mem  [icache_lines];
    logic [block_bits-1:0]      data_mem [icache_lines];
    logic [icache_lines-1:0]    line_valid;

    ic_state_t       state;
    logic [xlen-1:0] miss_addr;    // block aligned

    logic [icache_index_bits-1:0] rd_idx;
    logic [icache_index_bits-1:0] fill_idx;
    logic [icache_tag_bits-1:0]   rd_tag;
    logic                         lookup_hit;
    logic                         start_miss;
    logic                         fill_now;
    logic                         fill_match;

    assign rd_idx   = fetch_addr[block_offset_bits +: icache_index_bits];
    assign rd_tag   = fetch_addr[xlen-1 -: icache_tag_bits];
    assign fill_idx = miss_addr[block_offset_bits +: icache_index_bits];

    assign lookup_hit = line_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign start_miss = (state == ic_idle) && !lookup_hit;
    assign fill_now   = (state == ic_wait_fill) && mem_rsp.fill_valid;
    // fill block is the one fetch still asks for
    assign fill_match = fill_now &&
        (fetch_addr[xlen-1:block_offset_bits] == miss_addr[xlen-1:block_offset_bits]);

    always_comb begin
        mem_req.command = (state == ic_wait_accept) ? cmd_load : cmd_none;
        mem_req.addr    = miss_addr;
        mem_req.size    = size_double;
    end

    //////////////////////////////
    // control
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            state      <= ic_idle;
            line_valid <= '0;           // all lines invalid
            hit_valid  <= 1'b0;
        end else begin
            hit_valid <= ((state == ic_idle) && lookup_hit) || fill_match;
            case (state)
                ic_idle: begin
                    if (start_miss) state <= ic_wait_accept;
                end
                ic_wait_accept: begin
                    if (mem_rsp.accepted) state <= ic_wait_fill;
                end
                ic_wait_fill: begin
                    if (mem_rsp.fill_valid) begin
                        line_valid[fill_idx] <= 1'b1;
                        state                <= ic_idle;
                    end
                end
                default: state <= ic_idle;
            endcase
        end
    end

    //////////////////////////////
    // arrays and payload
    //////////////////////////////
    always_ff @(posedge clock) begin
        hit_data <= fill_match ? mem_rsp.fill_data : data_mem[rd_idx];    // bypass on fill
        if (start_miss) begin
            miss_addr <= {fetch_addr[xlen-1:block_offset_bits], {block_offset_bits{1'b0}}};
        end
        if (fill_now) begin
            tag_mem[fill_idx]  <= miss_addr[xlen-1 -: icache_tag_bits];
            data_mem[fill_idx] <= mem_rsp.fill_data;
        end
    end

endmodule

//--- fetch_stage.sv
// fetch stage, keeps the pc and turns cache answers into fetch packets
// presents one address per cycle, the cache answers it one cycle later
`timescale 1ns/1ps

module fetch_stage (
    input  logic                                clock,
    input  logic                                rst,
    input  pipe_defs_pkg::redirect_t            redirect,
    input  logic                                hit_valid,     // answer for last cycle's addr
    input  logic [sys_defs_pkg::block_bits-1:0] hit_data,
    output logic [sys_defs_pkg::xlen-1:0]       fetch_addr,
    output pipe_defs_pkg::fetch_packet_t        fetch_packet
);
    import sys_defs_pkg::*;
    import pipe_defs_pkg::*;

    logic [xlen-1:0] pc;        // address whose answer is due this cycle
    logic            squash;    // answer in flight belongs to the old path
    logic            take;

    assign take = hit_valid && !squash;

    // advance on a usable hit, else keep asking for the same pc
    assign fetch_addr = take ? pc + xlen'(word_bits / 8) : pc;

    always_comb begin
        fetch_packet.valid = take;
        fetch_packet.pc    = pc;
        // pc bit 2 picks the upper word of the block
        if (pc[2]) begin
            fetch_packet.inst = hit_data[block_bits-1:word_bits];
        end else begin
            fetch_packet.inst = hit_data[word_bits-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pc     <= reset_pc;
            squash <= 1'b0;
        end else if (redirect.valid) begin
            pc     <= redirect.target;   // live next cycle
            squash <= 1'b1;              // drop answer for this cycle's addr
        end else begin
            pc     <= fetch_addr;
            squash <= 1'b0;
        end
    end

endmodule

//--- pipe_defs_pkg.sv
// pipeline-level definitions for the fetch path and the load path
// structs here travel between the top level and the stage modules
package pipe_defs_pkg;

    localparam int word_bits = 32;                          // one instruction or load word
    localparam logic [sys_defs_pkg::xlen-1:0] reset_pc = '0;

    typedef struct packed {
        logic                          valid;
        logic [sys_defs_pkg::xlen-1:0] pc;
        logic [word_bits-1:0]          inst;
    } fetch_packet_t;

    // branch outcome from outside, single-cycle strobe
    typedef struct packed {
        logic                          valid;
        logic [sys_defs_pkg::xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                          valid;
        logic [sys_defs_pkg::xlen-1:0] addr;
    } load_req_t;

    typedef struct packed {
        logic                          valid;
        logic [sys_defs_pkg::xlen-1:0] addr;
        logic [word_bits-1:0]          data;
    } load_result_t;

endpackage

//--- sys_defs_pkg.sv
// bus-level definitions shared by the memory clients and the arbiter
// covers the tagged memory protocol: commands, sizes and per-client port structs
package sys_defs_pkg;

    localparam int xlen         = 32;                       // address width
    localparam int block_bits   = 64;                       // memory data bus
    localparam int num_tags     = 16;                       // tag 0 means no tag
    localparam int tag_bits     = $clog2(num_tags);
    localparam int icache_lines = 32;

    // derived block and cache geometry
    localparam int block_offset_bits = $clog2(block_bits / 8);     // 3, byte offset in block
    localparam int icache_index_bits = $clog2(icache_lines);       // 5, addr bits 7:3
    localparam int icache_tag_bits   = xlen - icache_index_bits - block_offset_bits;

    typedef enum logic [1:0] {
        cmd_none  = 2'h0,
        cmd_load  = 2'h1,
        cmd_store = 2'h2      // never issued here
    } mem_command_t;

    typedef enum logic [1:0] {
        size_byte   = 2'h0,
        size_half   = 2'h1,
        size_word   = 2'h2,
        size_double = 2'h3
    } mem_size_t;

    // client -> arbiter, held until accepted
    typedef struct packed {
        mem_command_t    command;
        logic [xlen-1:0] addr;       // block aligned
        mem_size_t       size;
    } mem_req_t;

    // arbiter -> client
    typedef struct packed {
        logic                  accepted;     // one-cycle pulse, same cycle as grant
        logic                  fill_valid;   // returned data belongs to this client
        logic [block_bits-1:0] fill_data;
    } mem_port_rsp_t;

endpackage
